//--- source/fft_pkg.sv
`default_nettype none

package fft_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int DATA_WID     = 16;
    localparam int FFT_LEN      = 8;
    localparam int LOG2_FFT_LEN = 3;

    // Twiddles are Q1.14
    localparam int TWID_FRAC    = 14;

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic signed [DATA_WID-1:0] re;
        logic signed [DATA_WID-1:0] im;
    } complex_t;

    // Slot 0 sits in the low bits
    typedef complex_t [FFT_LEN-1:0] frame_t;

    // One whole frame moving between pipeline ranks
    typedef struct packed {
        logic   valid;
        frame_t data;
    } stage_bus_t;

    // ------------------------------------------------------------------------
    // Twiddle table
    // ------------------------------------------------------------------------
    // cos and sin of 2*pi*k/8, the butterfly applies w = cos - j*sin
    localparam logic signed [DATA_WID-1:0] TWID_COS [FFT_LEN/2] = '{
        16'sd16384,
        16'sd11585,
        16'sd0,
        -16'sd11585
    };

    localparam logic signed [DATA_WID-1:0] TWID_SIN [FFT_LEN/2] = '{
        16'sd0,
        16'sd11585,
        16'sd16384,
        16'sd11585
    };

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    // Mirror the index bits, used to place input samples
    function automatic logic [LOG2_FFT_LEN-1:0] bit_rev(
        input logic [LOG2_FFT_LEN-1:0] idx
    );
        logic [LOG2_FFT_LEN-1:0] rev;
        for (int i = 0; i < LOG2_FFT_LEN; i++) begin
            rev[i] = idx[LOG2_FFT_LEN-1-i];
        end
        return rev;
    endfunction

endpackage

`default_nettype wire

//--- source/sample_loader.sv
`default_nettype none

module sample_loader import fft_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        val_i,
    input  complex_t   sample_i,
    output stage_bus_t frame_o
);

    // Position of the next sample within the frame
    logic [LOG2_FFT_LEN-1:0] cnt;

    // ------------------------------------------------------------------------
    // Serial to parallel
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt     <= '0;
            frame_o <= '0;
        end else if (val_i) begin
            // Decimation in time wants the input in bit-reversed slots
            frame_o.data[bit_rev(cnt)] <= sample_i;
            cnt                        <= cnt + 1'b1;

            // Pulse on the eighth sample
            frame_o.valid <= (cnt == LOG2_FFT_LEN'(FFT_LEN - 1));
        end else begin
            // Gap in the stream drops the partial frame
            cnt           <= '0;
            frame_o.valid <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // A frame can only close on a cycle that carried a sample
    a_valid_after_sample: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_o.valid |-> $past(val_i)
    );

endmodule

`default_nettype wire

//--- source/butterfly_stage.sv
`default_nettype none

module butterfly_stage import fft_pkg::*; #(
    parameter int STAGE = 0
) (
    input  wire        clk,
    input  wire        rst_n,
    input  stage_bus_t bus_i,
    output stage_bus_t bus_o
);

    // Combinational result of this rank
    wire frame_t nxt_data;

    // ------------------------------------------------------------------------
    // Butterflies
    // ------------------------------------------------------------------------
    for (genvar p = 0; p < FFT_LEN / 2; p++) begin : g_bfly
        // Pair distance and where this butterfly sits in its group
        localparam int SPAN = 1 << STAGE;
        localparam int POS  = p % SPAN;
        localparam int GRP  = p / SPAN;
        localparam int TOP  = GRP * 2 * SPAN + POS;
        localparam int BOT  = TOP + SPAN;
        localparam int TW   = POS * (FFT_LEN / (2 * SPAN));

        localparam logic signed [DATA_WID-1:0] W_COS = TWID_COS[TW];
        localparam logic signed [DATA_WID-1:0] W_SIN = TWID_SIN[TW];

        complex_t                     a;
        complex_t                     b;
        logic signed [2*DATA_WID:0]   prod_re;
        logic signed [2*DATA_WID:0]   prod_im;
        logic signed [2*DATA_WID+1:0] top_re;
        logic signed [2*DATA_WID+1:0] top_im;
        logic signed [2*DATA_WID+1:0] bot_re;
        logic signed [2*DATA_WID+1:0] bot_im;

        assign a = bus_i.data[TOP];
        assign b = bus_i.data[BOT];

        // b times conj of exp(j*2*pi*k/N) at full precision
        assign prod_re = b.re * W_COS + b.im * W_SIN;
        assign prod_im = b.im * W_COS - b.re * W_SIN;

        // Drop the twiddle fraction before the add and subtract
        assign top_re = a.re + (prod_re >>> TWID_FRAC);
        assign top_im = a.im + (prod_im >>> TWID_FRAC);
        assign bot_re = a.re - (prod_re >>> TWID_FRAC);
        assign bot_im = a.im - (prod_im >>> TWID_FRAC);

        // Bits [16:1] halve the result so growth stays in 16 bits
        assign nxt_data[TOP] = '{
            re: top_re[DATA_WID:1],
            im: top_im[DATA_WID:1]
        };
        assign nxt_data[BOT] = '{
            re: bot_re[DATA_WID:1],
            im: bot_im[DATA_WID:1]
        };
    end

    // ------------------------------------------------------------------------
    // Rank register
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus_o <= '0;
        end else begin
            bus_o.valid <= bus_i.valid;
            // Hold the last frame while nothing new arrives
            if (bus_i.valid) begin
                bus_o.data <= nxt_data;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // Exactly one cycle of latency per rank
    a_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_o.valid == $past(bus_i.valid)
    );

endmodule

`default_nettype wire

//--- source/spectrum_unloader.sv
`default_nettype none

module spectrum_unloader import fft_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  stage_bus_t bus_i,
    output logic       val_o,
    output complex_t   sample_o
);

    frame_t                  spec_buf;
    // Next bin to send
    // Zero when idle or when bin 7 is on the output
    logic [LOG2_FFT_LEN-1:0] cnt;

    // ------------------------------------------------------------------------
    // Capture the spectrum
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spec_buf <= '0;
        end else if (bus_i.valid) begin
            spec_buf <= bus_i.data;
        end
    end

    // ------------------------------------------------------------------------
    // Parallel to serial
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            val_o    <= 1'b0;
            sample_o <= '0;
        end else if (bus_i.valid) begin
            // Bin 0 goes straight out
            cnt      <= LOG2_FFT_LEN'(1);
            val_o    <= 1'b1;
            sample_o <= bus_i.data[0];
        end else if (cnt != '0) begin
            cnt      <= cnt + 1'b1;
            val_o    <= 1'b1;
            sample_o <= spec_buf[cnt];
        end else begin
            val_o    <= 1'b0;
            sample_o <= '0;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    // New frame only when idle or while bin 7 is showing
    a_no_overrun: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_i.valid |-> (cnt == '0)
    );

endmodule

`default_nettype wire

//--- source/fft_top.sv
`default_nettype none

module fft_top import fft_pkg::*; (
    input  wire      clk,
    input  wire      rst_n,
    input  wire      val_i,
    input  complex_t sample_i,
    output logic     val_o,
    output complex_t sample_o
);

    // Bus 0 from the loader, bus k+1 from stage k
    stage_bus_t stage_bus [LOG2_FFT_LEN+1];

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    sample_loader u_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .val_i    (val_i),
        .sample_i (sample_i),
        .frame_o  (stage_bus[0])
    );

    // ------------------------------------------------------------------------
    // Butterfly pipeline, one rank per stage
    // ------------------------------------------------------------------------
    for (genvar s = 0; s < LOG2_FFT_LEN; s++) begin : g_stage
        butterfly_stage #(
            .STAGE (s)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .bus_i (stage_bus[s]),
            .bus_o (stage_bus[s+1])
        );
    end

    // ------------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------------
    spectrum_unloader u_unloader (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_i    (stage_bus[LOG2_FFT_LEN]),
        .val_o    (val_o),
        .sample_o (sample_o)
    );

endmodule

`default_nettype wire

//--- bench/clock_gen.sv
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o   = 1'b0;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        // Release away from the edge
        #10;
        rst_n_o = 1'b1;
    end

    always #(PERIOD_NS / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- bench/fft_tb.sv
`default_nettype none

module fft_tb import fft_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 100;
    localparam int IN_DELAY        = 10;
    localparam int NUM_FRAMES      = 11;
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * 20 + 50;
    localparam int MAX_BINS        = 128;
    localparam int DRAIN_LIMIT     = 20;
    // First bin leaves 4 cycles after the eighth sample
    localparam int FIRST_LAT       = 4;
    localparam int HIST_LEN        = FIRST_LAT + FFT_LEN;

    // Q1.14 cos and sin of 2*pi*k/8
    localparam longint COS_Q14 [FFT_LEN/2] = '{16384, 11585, 0, -11585};
    localparam longint SIN_Q14 [FFT_LEN/2] = '{0, 11585, 16384, 11585};

    logic                clk;
    logic                rst_n;
    logic                val_i;
    complex_t            sample_i;
    logic                val_o;
    complex_t            sample_o;

    logic                last_sample;
    logic [HIST_LEN-1:0] last_hist;
    logic                exp_val;
    complex_t            tx_frame [FFT_LEN];
    complex_t            exp_bins [MAX_BINS];
    string               bin_test [MAX_BINS];
    int                  exp_cnt;
    int                  rd_idx;
    string               cur_test;
    logic [31:0]         lcg_state;

    clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) u_clock (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fft_top DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .val_i    (val_i),
        .sample_i (sample_i),
        .val_o    (val_o),
        .sample_o (sample_o)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic report_bin_mismatch(input int idx, input complex_t act);
        $display("[ERROR] %s bin %0d: expected (%0d, %0d), actual (%0d, %0d)",
                 bin_test[idx], idx % FFT_LEN, exp_bins[idx].re, exp_bins[idx].im,
                 act.re, act.im);
        stop_on_error();
    endtask

    function automatic int next_part();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[31:16] % 16'd16383) - 8191;
    endfunction

    function automatic int reverse_index(input int idx);
        int rev;
        rev = 0;
        for (int i = 0; i < LOG2_FFT_LEN; i++) begin
            rev = (rev << 1) | ((idx >> i) & 1);
        end
        return rev;
    endfunction

    // Keep the low 16 bits as a signed word
    function automatic longint wrap_word(input longint v);
        logic signed [DATA_WID-1:0] w;
        w = v[DATA_WID-1:0];
        return longint'(w);
    endfunction

    // ------------------------------------------------------------------------
    // Integer model of the radix-2 pipeline
    // ------------------------------------------------------------------------
    task automatic model_spectrum(input string name);
        longint w_re [FFT_LEN];
        longint w_im [FFT_LEN];
        longint t_re;
        longint t_im;
        int     span;
        int     pos;
        int     top;
        int     bot;
        int     tw;
        for (int n = 0; n < FFT_LEN; n++) begin
            w_re[reverse_index(n)] = tx_frame[n].re;
            w_im[reverse_index(n)] = tx_frame[n].im;
        end
        for (int s = 0; s < LOG2_FFT_LEN; s++) begin
            span = 1 << s;
            for (int p = 0; p < FFT_LEN / 2; p++) begin
                pos  = p % span;
                top  = (p / span) * 2 * span + pos;
                bot  = top + span;
                tw   = pos * (FFT_LEN / (2 * span));
                // b times (cos - j sin)
                t_re = (w_re[bot] * COS_Q14[tw] + w_im[bot] * SIN_Q14[tw]) >>> TWID_FRAC;
                t_im = (w_im[bot] * COS_Q14[tw] - w_re[bot] * SIN_Q14[tw]) >>> TWID_FRAC;
                w_re[bot] = wrap_word((w_re[top] - t_re) >>> 1);
                w_im[bot] = wrap_word((w_im[top] - t_im) >>> 1);
                w_re[top] = wrap_word((w_re[top] + t_re) >>> 1);
                w_im[top] = wrap_word((w_im[top] + t_im) >>> 1);
            end
        end
        for (int k = 0; k < FFT_LEN; k++) begin
            exp_bins[exp_cnt].re = DATA_WID'(w_re[k]);
            exp_bins[exp_cnt].im = DATA_WID'(w_im[k]);
            bin_test[exp_cnt]    = name;
            exp_cnt++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic drive_idle();
        @(posedge clk);
        #IN_DELAY;
        val_i       = 1'b0;
        sample_i    = '0;
        last_sample = 1'b0;
    endtask

    task automatic send_frame(input string name);
        model_spectrum(name);
        cur_test = name;
        for (int n = 0; n < FFT_LEN; n++) begin
            @(posedge clk);
            #IN_DELAY;
            val_i       = 1'b1;
            sample_i    = tx_frame[n];
            last_sample = (n == FFT_LEN - 1);
        end
    endtask

    // Broken frame, nothing is expected from it
    task automatic send_partial(input string name, input int count);
        cur_test = name;
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            #IN_DELAY;
            val_i       = 1'b1;
            sample_i    = tx_frame[n];
            last_sample = 1'b0;
        end
    endtask

    task automatic fill_random();
        for (int n = 0; n < FFT_LEN; n++) begin
            tx_frame[n].re = DATA_WID'(next_part());
            tx_frame[n].im = DATA_WID'(next_part());
        end
    endtask

    task automatic fill_constant(input int c_re, input int c_im);
        for (int n = 0; n < FFT_LEN; n++) begin
            tx_frame[n].re = DATA_WID'(c_re);
            tx_frame[n].im = DATA_WID'(c_im);
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (rd_idx != exp_cnt && cycles < DRAIN_LIMIT) begin
            drive_idle();
            cycles++;
        end
        if (rd_idx != exp_cnt) begin
            $display("Output burst of %s did not finish within %0d cycles",
                     cur_test, DRAIN_LIMIT);
            stop_on_error();
        end else begin
            repeat (3) drive_idle();
        end
    endtask

    // ------------------------------------------------------------------------
    // Output tracking
    // ------------------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_hist <= '0;
            rd_idx    <= 0;
        end else begin
            last_hist <= {last_hist[HIST_LEN-2:0], last_sample};
            if (val_o) begin
                rd_idx <= rd_idx + 1;
            end
        end
    end

    // Eight bins per closed frame, starting FIRST_LAT cycles later
    assign exp_val = |last_hist[HIST_LEN-1:FIRST_LAT];

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_val_timing: assert property (
        @(posedge clk) disable iff (!rst_n)
        val_o == exp_val
    ) else begin
        $display("[ERROR] %s: val_o expected %0b, actual %0b",
                 cur_test, $sampled(exp_val), $sampled(val_o));
        stop_on_error();
    end

    a_idle_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !val_o |-> (sample_o == '0)
    ) else begin
        $display("[ERROR] %s: idle sample_o expected 0x%08h, actual 0x%08h",
                 cur_test, 32'h0, $sampled(sample_o));
        stop_on_error();
    end

    a_no_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        val_o |-> (rd_idx < exp_cnt)
    ) else begin
        $display("Output bin appeared while no frame was pending in %s", cur_test);
        stop_on_error();
    end

    a_bin_value: assert property (
        @(posedge clk) disable iff (!rst_n)
        (val_o && rd_idx < exp_cnt) |-> (sample_o == exp_bins[rd_idx])
    ) else begin
        report_bin_mismatch($sampled(rd_idx), $sampled(sample_o));
    end

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without the run finishing",
                 WATCHDOG_CYCLES);
        stop_on_error();
    end

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        val_i       = 1'b0;
        sample_i    = '0;
        last_sample = 1'b0;
        exp_cnt     = 0;
        cur_test    = "reset";
        lcg_state   = 32'h70c9_9d21;

        wait (rst_n === 1'b1);

        cur_test = "idle after reset";
        repeat (20) drive_idle();

        // Impulse at slot 0
        fill_constant(0, 0);
        tx_frame[0] = '{re: 16'sd4096, im: -16'sd2048};
        send_frame("impulse");
        wait_for_drain();

        fill_constant(1000, -600);
        send_frame("constant positive");
        wait_for_drain();

        fill_constant(-3000, 2500);
        send_frame("constant negative");
        wait_for_drain();

        // Back to back
        for (int f = 0; f < 6; f++) begin
            fill_random();
            send_frame($sformatf("random frame %0d", f));
        end
        wait_for_drain();

        fill_random();
        send_partial("partial frame", 5);
        drive_idle();
        fill_random();
        send_frame("frame after gap");
        wait_for_drain();

        if (rd_idx != exp_cnt) begin
            $display("Run ended with %0d of %0d expected bins seen", rd_idx, exp_cnt);
            stop_on_error();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- project.f
source/fft_pkg.sv
source/sample_loader.sv
source/butterfly_stage.sv
source/spectrum_unloader.sv
source/fft_top.sv
bench/clock_gen.sv
bench/fft_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module fft_tb -f project.f \
    -o fft_sim > build.log 2>&1 \
    && ./obj_dir/fft_sim > sim.log 2>&1 \
    || echo "Build or simulation exited with an error status"

if [ -f sim.log ]; then cat sim.log; else cat build.log; fi

if [ ! -f sim.log ] || grep -q "Done: errors found" sim.log \
    || ! grep -q "Done: no errors" sim.log; then
    echo "FAIL"
    exit 1
fi
echo "PASS"
